// ==== sources.f ====
design/gyro_pkg.sv
design/gyro_regs.sv
design/square_mod_gen.sv
design/err_demod.sv
design/step_ramp_loop.sv
design/gyro_loop_top.sv
dv/gyro_tb_clk.sv
dv/gyro_tb.sv

// ==== Bender.yml ====
package:
  name: gyro_loop

sources:
  - design/gyro_pkg.sv
  - design/gyro_regs.sv
  - design/square_mod_gen.sv
  - design/err_demod.sv
  - design/step_ramp_loop.sv
  - design/gyro_loop_top.sv
  - target: test
    files:
      - dv/gyro_tb_clk.sv
      - dv/gyro_tb.sv

// ==== dv/gyro_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module gyro_tb;

	// cycle budget per test
	localparam int T_RESET = 20;
	localparam int T_MOD = 2 * 2 * 64 + 2 * 2 * 20 + 3 * 16;
	localparam int T_REGS = 24 * 16;
	localparam int T_DEMOD = 2 * (4 * 2 * 24 + 10 * 16);
	localparam int T_RAMP = 5 * 2 * 24 + 2 * 16;
	localparam int T_LOOP = 6 * 2 * 24 + 6 * 16;
	localparam int CYCLE_LIMIT = (3 * (T_RESET + T_MOD + T_REGS + T_DEMOD + T_RAMP + T_LOOP)) / 2;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam gyro_pkg::cnt_t HALF_LEN = 32'd24;

	logic CLOCK_DAC_1;
	logic arst_n;
	gyro_pkg::axi_addr_t awaddr;
	logic awvalid;
	logic o_awready;
	gyro_pkg::axi_data_t wdata;
	logic wvalid;
	logic o_wready;
	gyro_pkg::axi_resp_t o_bresp;
	logic o_bvalid;
	logic bready;
	gyro_pkg::axi_addr_t araddr;
	logic arvalid;
	logic o_arready;
	gyro_pkg::axi_data_t o_rdata;
	gyro_pkg::axi_resp_t o_rresp;
	logic o_rvalid;
	logic rready;
	gyro_pkg::sample_t adc;
	gyro_pkg::dac_t o_dac;
	logic o_sync;

	logic [31:0] lfsr_q;
	int cycles;
	// photodetector levels per half
	gyro_pkg::sample_t adc_h;
	gyro_pkg::sample_t adc_l;
	gyro_pkg::word_t exp_err;

	gyro_tb_clk gyro_tb_clk_i (
		.o_clk(CLOCK_DAC_1),
		.o_arst_n(arst_n)
	);

	gyro_loop_top gyro_loop_top_i (
		.CLOCK_DAC_1(CLOCK_DAC_1),
		.i_arst_n(arst_n),
		.i_awaddr(awaddr),
		.i_awvalid(awvalid),
		.o_awready(o_awready),
		.i_wdata(wdata),
		.i_wvalid(wvalid),
		.o_wready(o_wready),
		.o_bresp(o_bresp),
		.o_bvalid(o_bvalid),
		.i_bready(bready),
		.i_araddr(araddr),
		.i_arvalid(arvalid),
		.o_arready(o_arready),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.o_rvalid(o_rvalid),
		.i_rready(rready),
		.i_adc(adc),
		.o_dac(o_dac),
		.o_sync(o_sync)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			stop_run($sformatf("Fail %s expected 0x%h actual 0x%h", test, exp, act));
		end
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'd0);
		end
		return r;
	endfunction

	// outputs held at reset values while reset is low
	reset_values: assert property (@(posedge CLOCK_DAC_1) !arst_n |->
		(o_dac == '0 && o_sync && !o_bvalid && !o_rvalid && !o_awready && !o_wready &&
		!o_arready))
		else stop_run("outputs left their reset values during reset");

	// run length guard
	always @(posedge CLOCK_DAC_1) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_run("timeout, tests took longer than the cycle budget");
		end
	end

	// adc follows the modulation half
	always @(posedge CLOCK_DAC_1) begin
		adc <= o_sync ? adc_h : adc_l;
	end

	task automatic axi_write(input gyro_pkg::axi_addr_t addr, input gyro_pkg::axi_data_t data,
		output gyro_pkg::axi_resp_t resp);
		int delay;
		@(posedge CLOCK_DAC_1);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge CLOCK_DAC_1); while (!o_awready);
		@(posedge CLOCK_DAC_1);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// back-pressure on b
		delay = rand_bits(2);
		repeat (delay) @(posedge CLOCK_DAC_1);
		@(negedge CLOCK_DAC_1);
		assert (o_bvalid) else stop_run("write response dropped before bready");
		resp = o_bresp;
		@(posedge CLOCK_DAC_1);
		bready <= 1'b1;
		@(posedge CLOCK_DAC_1);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input gyro_pkg::axi_addr_t addr, output gyro_pkg::axi_data_t data,
		output gyro_pkg::axi_resp_t resp);
		int delay;
		@(posedge CLOCK_DAC_1);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge CLOCK_DAC_1); while (!o_arready);
		@(posedge CLOCK_DAC_1);
		arvalid <= 1'b0;
		delay = rand_bits(2);
		repeat (delay) @(posedge CLOCK_DAC_1);
		@(negedge CLOCK_DAC_1);
		assert (o_rvalid) else stop_run("read data dropped before rready");
		data = o_rdata;
		resp = o_rresp;
		@(posedge CLOCK_DAC_1);
		rready <= 1'b1;
		@(posedge CLOCK_DAC_1);
		rready <= 1'b0;
	endtask

	// write expecting okay
	task automatic write_reg(input string test, input gyro_pkg::axi_addr_t addr,
		input gyro_pkg::axi_data_t data);
		gyro_pkg::axi_resp_t resp;
		axi_write(addr, data, resp);
		check_eq({test, " bresp"}, gyro_pkg::RESP_OKAY, resp);
	endtask

	task automatic read_expect(input string test, input gyro_pkg::axi_addr_t addr,
		input gyro_pkg::axi_data_t exp, input gyro_pkg::axi_resp_t exp_resp);
		gyro_pkg::axi_data_t data;
		gyro_pkg::axi_resp_t resp;
		axi_read(addr, data, resp);
		check_eq({test, " rresp"}, exp_resp, resp);
		check_eq(test, exp, data);
	endtask

	// returns on the first falling clock edge of a high half
	task automatic wait_sync_rise();
		do @(negedge CLOCK_DAC_1); while (o_sync);
		do @(negedge CLOCK_DAC_1); while (!o_sync);
	endtask

	// runs from the first falling edge of a half to the first of the next
	task automatic check_half(input string test, input logic lvl, input gyro_pkg::dac_t exp_dac);
		int n;
		n = 1;
		@(negedge CLOCK_DAC_1);
		check_eq({test, " dac level"}, exp_dac, o_dac);
		while (o_sync == lvl) begin
			n++;
			@(negedge CLOCK_DAC_1);
		end
		check_eq({test, " half length"}, HALF_LEN, n);
	endtask

	task automatic mod_waveform();
		gyro_pkg::word_t amp_h;
		gyro_pkg::word_t amp_l;
		amp_h = rand_bits(32);
		amp_l = rand_bits(32);
		write_reg("mod", gyro_pkg::REG_FREQ_CNT, HALF_LEN);
		write_reg("mod", gyro_pkg::REG_AMP_H, amp_h);
		write_reg("mod", gyro_pkg::REG_AMP_L, amp_l);
		wait_sync_rise();
		for (int p = 0; p < 2; p++) begin
			check_half("mod high", 1'b1, amp_h[15:0]);
			check_half("mod low", 1'b0, amp_l[15:0]);
		end
	endtask

	task automatic reg_access();
		gyro_pkg::axi_addr_t addrs[9];
		logic [31:0] masks[9];
		logic [31:0] vals[9];
		gyro_pkg::axi_resp_t resp;
		addrs = '{gyro_pkg::REG_CTRL, gyro_pkg::REG_FREQ_CNT, gyro_pkg::REG_AMP_H,
			gyro_pkg::REG_AMP_L, gyro_pkg::REG_WAIT_CNT, gyro_pkg::REG_AVG_SEL,
			gyro_pkg::REG_GAIN_SEL, gyro_pkg::REG_CONST_STEP, gyro_pkg::REG_ERR_OFFSET};
		masks = '{32'h3, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
			32'h7, 32'h1f, 32'hffff_ffff, 32'hffff_ffff};
		for (int i = 0; i < 9; i++) begin
			vals[i] = rand_bits(32);
		end
		// short period so the loop keeps turning
		vals[1] = 32'd2 + rand_bits(4);
		for (int i = 0; i < 9; i++) begin
			write_reg("regs write", addrs[i], vals[i]);
		end
		for (int i = 0; i < 9; i++) begin
			read_expect("regs readback", addrs[i], vals[i] & masks[i], gyro_pkg::RESP_OKAY);
		end
		// unmapped hole between settings and monitors
		read_expect("unmapped read", 8'h30, 32'd0, gyro_pkg::RESP_SLVERR);
		axi_write(8'h30, rand_bits(32), resp);
		check_eq("unmapped write bresp", gyro_pkg::RESP_SLVERR, resp);
		for (int i = 0; i < 9; i++) begin
			read_expect("regs after unmapped write", addrs[i], vals[i] & masks[i],
				gyro_pkg::RESP_OKAY);
		end
	endtask

	task automatic demod_levels(input logic pol);
		gyro_pkg::word_t offset;
		adc_h = rand_bits(14);
		adc_l = rand_bits(14);
		offset = rand_bits(32);
		write_reg("demod", gyro_pkg::REG_CTRL, {30'd0, pol, 1'b0});
		write_reg("demod", gyro_pkg::REG_FREQ_CNT, HALF_LEN);
		write_reg("demod", gyro_pkg::REG_WAIT_CNT, 32'd4);
		write_reg("demod", gyro_pkg::REG_AVG_SEL, 32'd3);
		write_reg("demod", gyro_pkg::REG_ERR_OFFSET, offset);
		// expected error wraps in word arithmetic
		if (pol) begin
			exp_err = gyro_pkg::word_t'(adc_l) - gyro_pkg::word_t'(adc_h) + offset;
		end else begin
			exp_err = gyro_pkg::word_t'(adc_h) - gyro_pkg::word_t'(adc_l) + offset;
		end
		repeat (3) wait_sync_rise();
		repeat (3) @(negedge CLOCK_DAC_1);
		read_expect("demod high avg", gyro_pkg::REG_HIGH_AVG, gyro_pkg::word_t'(adc_h),
			gyro_pkg::RESP_OKAY);
		read_expect("demod low avg", gyro_pkg::REG_LOW_AVG, gyro_pkg::word_t'(adc_l),
			gyro_pkg::RESP_OKAY);
		read_expect("demod err", gyro_pkg::REG_ERR, exp_err, gyro_pkg::RESP_OKAY);
	endtask

	task automatic open_loop_ramp(input logic pol);
		gyro_pkg::word_t step;
		gyro_pkg::dac_t prev;
		gyro_pkg::dac_t exp_dac;
		step = rand_bits(32);
		write_reg("ramp", gyro_pkg::REG_CONST_STEP, step);
		write_reg("ramp", gyro_pkg::REG_CTRL, {30'd0, pol, 1'b0});
		repeat (2) wait_sync_rise();
		repeat (10) @(negedge CLOCK_DAC_1);
		prev = o_dac;
		for (int p = 0; p < 3; p++) begin
			wait_sync_rise();
			repeat (10) @(negedge CLOCK_DAC_1);
			// dac word wraps at 16 bits
			exp_dac = prev + step[15:0];
			check_eq("ramp dac", exp_dac, o_dac);
			prev = o_dac;
		end
	endtask

	task automatic closed_loop_step(input logic pol);
		gyro_pkg::gain_sel_t gain;
		gyro_pkg::word_t inc;
		gyro_pkg::axi_data_t prev;
		gyro_pkg::axi_data_t cur;
		gyro_pkg::axi_resp_t resp;
		gain = 5'd2 + rand_bits(2);
		// sign kept by the shift
		inc = exp_err >>> gain;
		write_reg("loop", gyro_pkg::REG_GAIN_SEL, gain);
		write_reg("loop", gyro_pkg::REG_CTRL, {30'd0, pol, 1'b1});
		wait_sync_rise();
		repeat (4) @(negedge CLOCK_DAC_1);
		axi_read(gyro_pkg::REG_STEP, prev, resp);
		check_eq("loop step rresp", gyro_pkg::RESP_OKAY, resp);
		for (int p = 0; p < 4; p++) begin
			wait_sync_rise();
			repeat (4) @(negedge CLOCK_DAC_1);
			axi_read(gyro_pkg::REG_STEP, cur, resp);
			check_eq("loop step rresp", gyro_pkg::RESP_OKAY, resp);
			check_eq("loop step", prev + inc, cur);
			prev = cur;
		end
	endtask

	initial begin
		lfsr_q = 32'hefb2_251a;
		cycles = 0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		adc = '0;
		adc_h = '0;
		adc_l = '0;
		exp_err = '0;
		@(posedge arst_n);
		// right after release
		@(negedge CLOCK_DAC_1);
		check_eq("reset dac", 32'd0, o_dac);
		check_eq("reset sync", 32'd1, o_sync);
		check_eq("reset valid ready", 32'd0,
			{o_bvalid, o_rvalid, o_awready, o_wready, o_arready});
		// phase still zero here
		mod_waveform();
		reg_access();
		demod_levels(1'b0);
		demod_levels(1'b1);
		open_loop_ramp(1'b1);
		closed_loop_step(1'b1);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/gyro_tb_clk.sv ====
`default_nettype none
`timescale 1ns/10ps

module gyro_tb_clk (
	output logic o_clk,
	output logic o_arst_n
);

	// 8 ns period
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// reset held over the first 10 rising edges
	initial begin
		o_arst_n <= 1'b0;
		repeat (10) @(posedge o_clk);
		o_arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/gyro_loop_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module gyro_loop_top (
	input wire logic CLOCK_DAC_1,
	input wire logic i_arst_n,
	// axi4-lite slave
	input wire gyro_pkg::axi_addr_t i_awaddr,
	input wire logic i_awvalid,
	output logic o_awready,
	input wire gyro_pkg::axi_data_t i_wdata,
	input wire logic i_wvalid,
	output logic o_wready,
	output gyro_pkg::axi_resp_t o_bresp,
	output logic o_bvalid,
	input wire logic i_bready,
	input wire gyro_pkg::axi_addr_t i_araddr,
	input wire logic i_arvalid,
	output logic o_arready,
	output gyro_pkg::axi_data_t o_rdata,
	output gyro_pkg::axi_resp_t o_rresp,
	output logic o_rvalid,
	input wire logic i_rready,
	// converters
	input wire gyro_pkg::sample_t i_adc,
	output gyro_pkg::dac_t o_dac,
	output logic o_sync
);

	gyro_pkg::loop_cfg_t cfg;
	gyro_pkg::mod_t mod;
	gyro_pkg::err_pkt_t err;
	gyro_pkg::word_t step;

	// high during the high modulation half
	assign o_sync = mod.status;

	gyro_regs gyro_regs_i (
		.CLOCK_DAC_1(CLOCK_DAC_1),
		.i_arst_n(i_arst_n),
		.i_awaddr(i_awaddr),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_wdata(i_wdata),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.o_bresp(o_bresp),
		.o_bvalid(o_bvalid),
		.i_bready(i_bready),
		.i_araddr(i_araddr),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.o_rvalid(o_rvalid),
		.i_rready(i_rready),
		.i_err(err),
		.i_step(step),
		.o_cfg(cfg)
	);

	// bias modulation
	square_mod_gen square_mod_gen_i (
		.CLOCK_DAC_1(CLOCK_DAC_1),
		.i_arst_n(i_arst_n),
		.i_cfg(cfg),
		.o_mod(mod)
	);

	// error from the photodetector samples
	err_demod err_demod_i (
		.CLOCK_DAC_1(CLOCK_DAC_1),
		.i_arst_n(i_arst_n),
		.i_adc(i_adc),
		.i_cfg(cfg),
		.i_mod(mod),
		.o_err(err)
	);

	// feedback step and phase ramp
	step_ramp_loop step_ramp_loop_i (
		.CLOCK_DAC_1(CLOCK_DAC_1),
		.i_arst_n(i_arst_n),
		.i_cfg(cfg),
		.i_mod(mod),
		.i_err(err),
		.o_step(step),
		.o_dac(o_dac)
	);

endmodule

`default_nettype wire

// ==== design/step_ramp_loop.sv ====
`default_nettype none
`timescale 1ns/10ps

module step_ramp_loop (
	input wire logic CLOCK_DAC_1,
	input wire logic i_arst_n,
	input wire gyro_pkg::loop_cfg_t i_cfg,
	input wire gyro_pkg::mod_t i_mod,
	input wire gyro_pkg::err_pkt_t i_err,
	output gyro_pkg::word_t o_step,
	output gyro_pkg::dac_t o_dac
);

	gyro_pkg::word_t step_q;
	gyro_pkg::word_t step_d;
	gyro_pkg::word_t phase_q;
	gyro_pkg::word_t dac_sum;

	// closed loop integrates scaled error, open loop holds const step
	assign step_d = i_cfg.fb_on ?
		(step_q + (i_err.err >>> i_cfg.gain_sel)) : i_cfg.const_step;

	// ramp plus bias, wraps to dac width
	assign dac_sum = phase_q + i_mod.level;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			step_q <= '0;
			phase_q <= '0;
			o_dac <= '0;
		end else begin
			// one update per modulation period
			if (i_err.trig) begin
				step_q <= step_d;
				// ramp advances by the step held before this update
				phase_q <= phase_q + step_q;
			end
			// low 16 bits to the dac
			o_dac <= dac_sum[15:0];
		end
	end

	assign o_step = step_q;

endmodule

`default_nettype wire

// ==== design/err_demod.sv ====
`default_nettype none
`timescale 1ns/10ps

module err_demod (
	input wire logic CLOCK_DAC_1,
	input wire logic i_arst_n,
	input wire gyro_pkg::sample_t i_adc,
	input wire gyro_pkg::loop_cfg_t i_cfg,
	input wire gyro_pkg::mod_t i_mod,
	output gyro_pkg::err_pkt_t o_err
);

	gyro_pkg::sample_t adc_meta_q;
	gyro_pkg::sample_t adc_q;
	gyro_pkg::avg_sel_t avg_eff;
	gyro_pkg::cnt_t win_len;
	gyro_pkg::cnt_t win_pos;
	gyro_pkg::cnt_t smp_cnt_q;
	gyro_pkg::word_t sum_q;
	gyro_pkg::word_t avg;
	gyro_pkg::word_t high_avg_q;
	gyro_pkg::word_t low_avg_q;
	gyro_pkg::word_t diff;
	gyro_pkg::word_t err_q;
	logic in_win;
	logic calc_q;
	logic trig_q;

	// averaging depth limited to 2^6 samples
	assign avg_eff = (i_cfg.avg_sel > gyro_pkg::AVG_SEL_MAX) ?
		gyro_pkg::AVG_SEL_MAX : i_cfg.avg_sel;
	assign win_len = 32'd1 << avg_eff;

	// settle skip, then window of win_len samples
	assign win_pos = smp_cnt_q - i_cfg.wait_cnt;
	assign in_win = (smp_cnt_q >= i_cfg.wait_cnt) && (win_pos < win_len);

	// arithmetic shift keeps sign of the sum
	assign avg = sum_q >>> avg_eff;

	// polarity swaps the halves
	assign diff = i_cfg.polarity ? (low_avg_q - high_avg_q) : (high_avg_q - low_avg_q);

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			adc_meta_q <= '0;
			adc_q <= '0;
			smp_cnt_q <= '0;
			sum_q <= '0;
			high_avg_q <= '0;
			low_avg_q <= '0;
			err_q <= '0;
			calc_q <= 1'b0;
			trig_q <= 1'b0;
		end else begin
			// two-stage resync of the adc bus
			adc_meta_q <= i_adc;
			adc_q <= adc_meta_q;
			// end of low half closes a full period
			calc_q <= i_mod.half_end && !i_mod.status;
			trig_q <= calc_q;
			if (i_mod.half_end) begin
				smp_cnt_q <= '0;
				sum_q <= '0;
				// latch the average of the half just ending
				if (i_mod.status) begin
					high_avg_q <= avg;
				end else begin
					low_avg_q <= avg;
				end
			end else begin
				smp_cnt_q <= smp_cnt_q + 32'd1;
				if (in_win) begin
					// sign extend into the 32 bit sum
					sum_q <= sum_q + gyro_pkg::word_t'(adc_q);
				end
			end
			// both averages settled by now
			if (calc_q) begin
				err_q <= diff + i_cfg.err_offset;
			end
		end
	end

	assign o_err = '{
		err: err_q,
		high_avg: high_avg_q,
		low_avg: low_avg_q,
		trig: trig_q
	};

endmodule

`default_nettype wire

// ==== design/square_mod_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module square_mod_gen (
	input wire logic CLOCK_DAC_1,
	input wire logic i_arst_n,
	input wire gyro_pkg::loop_cfg_t i_cfg,
	output gyro_pkg::mod_t o_mod
);

	gyro_pkg::half_e half_q;
	gyro_pkg::half_e half_d;
	gyro_pkg::cnt_t cnt_q;
	gyro_pkg::cnt_t period;
	gyro_pkg::word_t level_q;
	logic half_end;

	// clamp short periods
	assign period = (i_cfg.freq_cnt < gyro_pkg::FREQ_CNT_MIN) ?
		gyro_pkg::FREQ_CNT_MIN : i_cfg.freq_cnt;
	// down counter hits zero on the last cycle of a half
	assign half_end = (cnt_q == '0);

	always_comb begin
		half_d = half_q;
		if (half_end && half_q == gyro_pkg::HALF_HIGH) begin
			half_d = gyro_pkg::HALF_LOW;
		end else if (half_end) begin
			half_d = gyro_pkg::HALF_HIGH;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			half_q <= gyro_pkg::HALF_HIGH;
			cnt_q <= gyro_pkg::FREQ_CNT_RST - 32'd1;
			level_q <= '0;
		end else begin
			half_q <= half_d;
			// new period only picked up at a boundary
			cnt_q <= half_end ? (period - 32'd1) : (cnt_q - 32'd1);
			// level tracks the half it belongs to
			level_q <= (half_d == gyro_pkg::HALF_HIGH) ? i_cfg.amp_h : i_cfg.amp_l;
		end
	end

	assign o_mod = '{
		level: level_q,
		status: (half_q == gyro_pkg::HALF_HIGH),
		half_end: half_end
	};

endmodule

`default_nettype wire

// ==== design/gyro_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module gyro_regs (
	input wire logic CLOCK_DAC_1,
	input wire logic i_arst_n,
	// write address and data
	input wire gyro_pkg::axi_addr_t i_awaddr,
	input wire logic i_awvalid,
	output logic o_awready,
	input wire gyro_pkg::axi_data_t i_wdata,
	input wire logic i_wvalid,
	output logic o_wready,
	// write response
	output gyro_pkg::axi_resp_t o_bresp,
	output logic o_bvalid,
	input wire logic i_bready,
	// read address and data
	input wire gyro_pkg::axi_addr_t i_araddr,
	input wire logic i_arvalid,
	output logic o_arready,
	output gyro_pkg::axi_data_t o_rdata,
	output gyro_pkg::axi_resp_t o_rresp,
	output logic o_rvalid,
	input wire logic i_rready,
	// loop side
	input wire gyro_pkg::err_pkt_t i_err,
	input wire gyro_pkg::word_t i_step,
	output gyro_pkg::loop_cfg_t o_cfg
);

	gyro_pkg::loop_cfg_t cfg_q;
	gyro_pkg::loop_mon_t mon;
	gyro_pkg::axi_wr_state_e wr_state_q;
	gyro_pkg::axi_data_t rd_data;
	logic wr_fire;
	logic wr_ok;
	logic rd_fire;
	logic rd_ok;

	// latest loop values, no extra latching
	assign mon = '{
		err: i_err.err,
		high_avg: i_err.high_avg,
		low_avg: i_err.low_avg,
		step: i_step
	};

	// aw and w accepted together, only with no response pending
	assign wr_fire = (wr_state_q == gyro_pkg::WR_IDLE) && i_awvalid && i_wvalid;
	assign o_awready = wr_fire;
	assign o_wready = wr_fire;
	assign o_bvalid = (wr_state_q == gyro_pkg::WR_RESP);

	// one read in flight at a time
	assign rd_fire = i_arvalid && !o_rvalid;
	assign o_arready = rd_fire;

	assign o_cfg = cfg_q;

	// writable part of the map
	always_comb begin
		case (i_awaddr)
			gyro_pkg::REG_CTRL, gyro_pkg::REG_FREQ_CNT, gyro_pkg::REG_AMP_H,
			gyro_pkg::REG_AMP_L, gyro_pkg::REG_WAIT_CNT, gyro_pkg::REG_AVG_SEL,
			gyro_pkg::REG_GAIN_SEL, gyro_pkg::REG_CONST_STEP,
			gyro_pkg::REG_ERR_OFFSET: wr_ok = 1'b1;
			default: wr_ok = 1'b0;
		endcase
	end

	// read mux, fields zero extended
	always_comb begin
		rd_ok = 1'b1;
		rd_data = '0;
		case (i_araddr)
			gyro_pkg::REG_CTRL: rd_data = {30'd0, cfg_q.polarity, cfg_q.fb_on};
			gyro_pkg::REG_FREQ_CNT: rd_data = cfg_q.freq_cnt;
			gyro_pkg::REG_AMP_H: rd_data = cfg_q.amp_h;
			gyro_pkg::REG_AMP_L: rd_data = cfg_q.amp_l;
			gyro_pkg::REG_WAIT_CNT: rd_data = cfg_q.wait_cnt;
			gyro_pkg::REG_AVG_SEL: rd_data = {29'd0, cfg_q.avg_sel};
			gyro_pkg::REG_GAIN_SEL: rd_data = {27'd0, cfg_q.gain_sel};
			gyro_pkg::REG_CONST_STEP: rd_data = cfg_q.const_step;
			gyro_pkg::REG_ERR_OFFSET: rd_data = cfg_q.err_offset;
			gyro_pkg::REG_ERR: rd_data = mon.err;
			gyro_pkg::REG_HIGH_AVG: rd_data = mon.high_avg;
			gyro_pkg::REG_LOW_AVG: rd_data = mon.low_avg;
			gyro_pkg::REG_STEP: rd_data = mon.step;
			default: rd_ok = 1'b0;
		endcase
	end

	// write fsm and setting registers
	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_state_q <= gyro_pkg::WR_IDLE;
			cfg_q <= '{freq_cnt: gyro_pkg::FREQ_CNT_RST, default: '0};
		end else begin
			case (wr_state_q)
				gyro_pkg::WR_IDLE: begin
					if (wr_fire) begin
						wr_state_q <= gyro_pkg::WR_RESP;
					end
				end
				gyro_pkg::WR_RESP: begin
					// hold b until the master takes it
					if (i_bready) begin
						wr_state_q <= gyro_pkg::WR_IDLE;
					end
				end
				default: wr_state_q <= gyro_pkg::WR_IDLE;
			endcase
			// strobes ignored, full word written
			if (wr_fire) begin
				case (i_awaddr)
					gyro_pkg::REG_CTRL: begin
						cfg_q.fb_on <= i_wdata[0];
						cfg_q.polarity <= i_wdata[1];
					end
					gyro_pkg::REG_FREQ_CNT: cfg_q.freq_cnt <= i_wdata;
					gyro_pkg::REG_AMP_H: cfg_q.amp_h <= i_wdata;
					gyro_pkg::REG_AMP_L: cfg_q.amp_l <= i_wdata;
					gyro_pkg::REG_WAIT_CNT: cfg_q.wait_cnt <= i_wdata;
					gyro_pkg::REG_AVG_SEL: cfg_q.avg_sel <= i_wdata[2:0];
					gyro_pkg::REG_GAIN_SEL: cfg_q.gain_sel <= i_wdata[4:0];
					gyro_pkg::REG_CONST_STEP: cfg_q.const_step <= i_wdata;
					gyro_pkg::REG_ERR_OFFSET: cfg_q.err_offset <= i_wdata;
					default: ;
				endcase
			end
		end
	end

	// read valid flag
	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rvalid <= 1'b0;
		end else if (rd_fire) begin
			o_rvalid <= 1'b1;
		end else if (i_rready) begin
			o_rvalid <= 1'b0;
		end
	end

	// response payloads, only looked at while valid
	always_ff @(posedge CLOCK_DAC_1) begin
		if (wr_fire) begin
			o_bresp <= wr_ok ? gyro_pkg::RESP_OKAY : gyro_pkg::RESP_SLVERR;
		end
		if (rd_fire) begin
			o_rdata <= rd_data;
			o_rresp <= rd_ok ? gyro_pkg::RESP_OKAY : gyro_pkg::RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

// ==== design/gyro_pkg.sv ====
`default_nettype none

package gyro_pkg;

	// loop data widths
	typedef logic signed [13:0] sample_t;
	typedef logic signed [31:0] word_t;
	typedef logic [31:0] cnt_t;
	typedef logic [15:0] dac_t;

	// register bus widths
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	// shift selects for averaging and loop gain
	typedef logic [2:0] avg_sel_t;
	typedef logic [4:0] gain_sel_t;

	// modulation half, high half comes first after reset
	typedef enum logic {
		HALF_HIGH,
		HALF_LOW
	} half_e;

	// write channel of the register slave
	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} axi_wr_state_e;

	// settings driven by the register block
	typedef struct packed {
		cnt_t freq_cnt;
		word_t amp_h;
		word_t amp_l;
		cnt_t wait_cnt;
		avg_sel_t avg_sel;
		logic polarity;
		word_t err_offset;
		logic fb_on;
		gain_sel_t gain_sel;
		word_t const_step;
	} loop_cfg_t;

	// bias modulation state
	typedef struct packed {
		word_t level;
		logic status;
		logic half_end;
	} mod_t;

	// demodulator result, trig marks a fresh err
	typedef struct packed {
		word_t err;
		word_t high_avg;
		word_t low_avg;
		logic trig;
	} err_pkt_t;

	// read-back monitors
	typedef struct packed {
		word_t err;
		word_t high_avg;
		word_t low_avg;
		word_t step;
	} loop_mon_t;

	// writable registers
	localparam axi_addr_t REG_CTRL = 8'h00;
	localparam axi_addr_t REG_FREQ_CNT = 8'h04;
	localparam axi_addr_t REG_AMP_H = 8'h08;
	localparam axi_addr_t REG_AMP_L = 8'h0C;
	localparam axi_addr_t REG_WAIT_CNT = 8'h10;
	localparam axi_addr_t REG_AVG_SEL = 8'h14;
	localparam axi_addr_t REG_GAIN_SEL = 8'h18;
	localparam axi_addr_t REG_CONST_STEP = 8'h1C;
	localparam axi_addr_t REG_ERR_OFFSET = 8'h20;
	// read-only monitors
	localparam axi_addr_t REG_ERR = 8'h40;
	localparam axi_addr_t REG_HIGH_AVG = 8'h44;
	localparam axi_addr_t REG_LOW_AVG = 8'h48;
	localparam axi_addr_t REG_STEP = 8'h4C;

	localparam axi_resp_t RESP_OKAY = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;

	// 64 samples at most per half
	localparam avg_sel_t AVG_SEL_MAX = 3'd6;
	localparam cnt_t FREQ_CNT_RST = 32'd64;
	// shortest legal half period
	localparam cnt_t FREQ_CNT_MIN = 32'd2;

endpackage

`default_nettype wire
